/* build.f */
source/rvseed_pkg.sv
source/rvseed_decode.sv
source/rvseed_regfile.sv
source/rvseed_operand.sv
source/rvseed_execute.sv
source/rvseed_core.sv
sim/rvseed_chk.sv
sim/rvseed_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the rvseed testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=rvseed_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module rvseed_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG_FILE"; then
    exit 1
fi
exit 0

/* sim/rvseed_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module rvseed_chk import rvseed_pkg::*; (
    input wire          clk,
    input wire          rst_n,
    input wire          in_valid,
    input wire          in_ready,
    input wire          out_valid,
    input wire          out_ready,
    input wire commit_t out_data
);

    int fail_cnt = 0; // failed assertions so far
    int in_flight;    // accepted but not yet committed

    always_ff @(posedge clk) begin
        if (!rst_n)
            in_flight <= 0;
        else
            in_flight <= in_flight + int'(in_valid && in_ready) - int'(out_valid && out_ready);
    end

    out_idle_after_reset: assert property (@(posedge clk) !rst_n |=> !out_valid && in_ready)
        else begin
            fail_cnt++;
            $error("out_valid high or in_ready low right after reset");
        end

    out_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            fail_cnt++;
            $error("commit record dropped or changed while out_ready was low");
        end

    in_ready_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        in_flight == 0 |-> in_ready)
        else begin
            fail_cnt++;
            $error("in_ready low with an empty pipeline");
        end

endmodule

bind rvseed_core rvseed_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

`default_nettype wire

/* sim/rvseed_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rvseed_tb import rvseed_pkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_INSTS   = 3000;
    localparam int STALL_ALLOW = 16; // worst-case cycles per instruction
    localparam int WATCHDOG_NS = (NUM_INSTS * STALL_ALLOW + 50) * CLK_PERIOD;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            in_valid;
    logic            in_ready;
    fetch_t          in_data;
    logic            out_valid;
    logic            out_ready;
    commit_t         out_data;

    logic [31:0]     lfsr_state = 32'h6a41_cd45;
    logic [XLEN-1:0] model_regs [32];
    fetch_t          pending [$];
    logic [XLEN-1:0] feed_pc;
    logic            in_fired;
    int              issued;
    int              accepted_cnt;
    int              commit_cnt;
    int              error_cnt;

    rvseed_core DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic step_lfsr();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], step_lfsr()};
        end
        return v;
    endfunction

    function automatic logic [4:0] pick_reg();
        if (rand_bits(3) == 0)
            return 5'(rand_bits(5));
        else
            return 5'(rand_bits(3)); // x0..x7 keeps dependencies frequent
    endfunction

    function automatic logic [31:0] gen_inst();
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [31:0] inst;
        kind  = 4'(rand_bits(4));
        rd    = pick_reg();
        rs1   = pick_reg();
        rs2   = pick_reg();
        f3    = 3'(rand_bits(3));
        imm12 = 12'(rand_bits(12));
        imm20 = 20'(rand_bits(20));
        case (kind)
            4'd0, 4'd1, 4'd2:
                inst = {rand_bits(1) ? 7'h20 : 7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
            4'd3, 4'd4, 4'd5:
                inst = {imm12, rs1, 3'b000, rd, 7'b0010011};
            4'd6:    inst = {imm20, rd, 7'b0110111}; // lui
            4'd7:    inst = {imm20, rd, 7'b0010111}; // auipc
            4'd8, 4'd9:
                inst = {imm12[11:5], rs2, rs1, 3'b001, imm12[4:0], 7'b1100011};
            4'd10:   inst = {imm12[11:5], rs2, rs1, 3'b011, imm12[4:0], 7'b0100011};
            4'd11:   inst = {imm20, rd, 7'b1101111}; // jal
            4'd12:   inst = {imm12, rs1, 3'b000, rd, 7'b1100111}; // jalr
            4'd13:   inst = rand_bits(32); // mostly illegal
            4'd14: begin
                if (rand_bits(1) != 0)
                    inst = 32'h0010_0073; // ebreak
                else
                    inst = {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b0100011};
            end
            default: inst = {imm12, rd, 3'b000, rd, 7'b0010011}; // addi chain on rd
        endcase
        return inst;
    endfunction

    function automatic logic [XLEN-1:0] next_feed_pc();
        logic [31:0] hi;
        logic [29:0] lo;
        if (rand_bits(4) == 0) begin
            hi      = rand_bits(32);
            lo      = 30'(rand_bits(30));
            feed_pc = {hi, lo, 2'b00};
        end else begin
            feed_pc = feed_pc + 64'd4;
        end
        return feed_pc;
    endfunction

    function automatic logic [XLEN-1:0] imm_i(input logic [31:0] i);
        logic signed [11:0] v;
        v = i[31:20];
        return 64'(v);
    endfunction

    function automatic logic [XLEN-1:0] imm_s(input logic [31:0] i);
        logic signed [11:0] v;
        v = {i[31:25], i[11:7]};
        return 64'(v);
    endfunction

    function automatic logic [XLEN-1:0] imm_b(input logic [31:0] i);
        logic signed [12:0] v;
        v = {i[31], i[7], i[30:25], i[11:8], 1'b0};
        return 64'(v);
    endfunction

    function automatic logic [XLEN-1:0] imm_j(input logic [31:0] i);
        logic signed [20:0] v;
        v = {i[31], i[19:12], i[20], i[30:21], 1'b0};
        return 64'(v);
    endfunction

    function automatic logic [XLEN-1:0] imm_u(input logic [31:0] i);
        logic signed [31:0] v;
        v = {i[31:12], 12'b0};
        return 64'(v);
    endfunction

    // ISA-level execution of one instruction, in program order
    task automatic run_model(input fetch_t f, output commit_t exp);
        logic [31:0]     i;
        logic [4:0]      rd;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] pc4;
        logic [XLEN-1:0] value;
        logic            writes;
        logic            legal;
        i      = f.inst;
        rd     = i[11:7];
        a      = model_regs[i[19:15]];
        b      = model_regs[i[24:20]];
        pc4    = f.pc + 64'd4;
        value  = '0;
        writes = 1'b0;
        legal  = 1'b1;
        exp         = '0;
        exp.pc      = f.pc;
        exp.inst    = i;
        exp.next_pc = pc4;
        case (i[6:0])
            7'b0110011: begin
                writes = (i[14:12] == 3'b000) && (i[31:25] == 7'h00 || i[31:25] == 7'h20);
                legal  = writes;
                value  = (i[31:25] == 7'h20) ? a - b : a + b;
            end
            7'b0010011: begin
                legal  = (i[14:12] == 3'b000);
                writes = legal;
                value  = a + imm_i(i);
            end
            7'b1100011: begin
                legal = (i[14:12] == 3'b001);
                if (legal && a != b)
                    exp.next_pc = f.pc + imm_b(i);
            end
            7'b0100011: begin
                legal = (i[14:12] == 3'b011);
                if (legal) begin
                    exp.store      = 1'b1;
                    exp.store_addr = a + imm_s(i);
                    exp.store_data = b;
                end
            end
            7'b1101111: begin
                writes      = 1'b1;
                value       = pc4;
                exp.next_pc = f.pc + imm_j(i);
            end
            7'b1100111: begin
                legal  = (i[14:12] == 3'b000);
                writes = legal;
                value  = pc4;
                if (legal)
                    exp.next_pc = (a + imm_i(i)) & ~64'd1;
            end
            7'b0110111: begin
                writes = 1'b1;
                value  = imm_u(i);
            end
            7'b0010111: begin
                writes = 1'b1;
                value  = f.pc + imm_u(i);
            end
            7'b1110011: begin
                exp.halt = (i == 32'h0010_0073);
                legal    = exp.halt;
            end
            default: legal = 1'b0;
        endcase
        exp.illegal = !legal;
        exp.rd      = writes ? rd : 5'd0;
        exp.wen     = writes && (rd != 5'd0);
        if (exp.wen) begin
            exp.wdata      = value;
            model_regs[rd] = value;
        end
    endtask

    task automatic check_field(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        assert (got === exp) else begin
            error_cnt++;
            $display("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_commit(input commit_t got);
        fetch_t  f;
        commit_t exp;
        assert (pending.size() > 0) else begin
            error_cnt++;
            $display("commit at %0t with no instruction outstanding", $time);
        end
        if (pending.size() > 0) begin
            f = pending.pop_front();
            run_model(f, exp);
            check_field("out_data.pc", got.pc, exp.pc);
            check_field("out_data.next_pc", got.next_pc, exp.next_pc);
            check_field("out_data.inst", got.inst, exp.inst);
            check_field("out_data.rd", got.rd, exp.rd);
            check_field("out_data.wen", got.wen, exp.wen);
            check_field("out_data.wdata", got.wdata, exp.wdata);
            check_field("out_data.store", got.store, exp.store);
            check_field("out_data.store_addr", got.store_addr, exp.store_addr);
            check_field("out_data.store_data", got.store_data, exp.store_data);
            check_field("out_data.halt", got.halt, exp.halt);
            check_field("out_data.illegal", got.illegal, exp.illegal);
        end
    endtask

    task automatic drive_inputs();
        if (!in_valid || in_fired) begin // payload holds until accepted
            if (issued < NUM_INSTS && rand_bits(2) != 0) begin
                in_data.pc   = next_feed_pc();
                in_data.inst = gen_inst();
                in_valid     = 1'b1;
                issued++;
            end else begin
                in_valid = 1'b0;
            end
        end
        out_ready = (rand_bits(3) >= 3);
    endtask

    task automatic finish_run(input bit timed_out);
        int chk_errs;
        chk_errs = DUT.u_chk.fail_cnt;
        $display("errors: scoreboard %0d, handshake %0d, timeout %0d",
                 error_cnt, chk_errs, timed_out);
        if (error_cnt == 0 && chk_errs == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            in_fired = 1'b0;
        end else begin
            in_fired = in_valid && in_ready;
            if (in_fired) begin
                pending.push_back(in_data);
                accepted_cnt++;
            end
            if (out_valid && out_ready) begin
                commit_cnt++;
                check_commit(out_data);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d of %0d commits", commit_cnt, NUM_INSTS);
        finish_run(1'b1);
    end

    initial begin
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        out_ready    = 1'b0;
        in_fired     = 1'b0;
        feed_pc      = 64'h0000_0000_8000_0000;
        issued       = 0;
        accepted_cnt = 0;
        commit_cnt   = 0;
        error_cnt    = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while (commit_cnt < NUM_INSTS) begin
            @(negedge clk);
            drive_inputs();
        end
        @(negedge clk);
        in_valid  = 1'b0;
        out_ready = 1'b1;
        repeat (8) @(negedge clk); // late or repeated commits would show here
        assert (pending.size() == 0) else begin
            error_cnt++;
            $display("%0d accepted instructions never committed", pending.size());
        end
        assert (accepted_cnt == NUM_INSTS) else begin
            error_cnt++;
            $display("MISMATCH time=%0t accepted_cnt got=%0d exp=%0d",
                     $time, accepted_cnt, NUM_INSTS);
        end
        assert (commit_cnt == accepted_cnt) else begin
            error_cnt++;
            $display("MISMATCH time=%0t commit_cnt got=%0d exp=%0d",
                     $time, commit_cnt, accepted_cnt);
        end
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

/* source/rvseed_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rvseed_core import rvseed_pkg::*; (
    input  wire          clk,
    input  wire          rst_n,
    input  wire          in_valid,
    output logic         in_ready,
    input  wire fetch_t  in_data,
    output logic         out_valid,
    input  wire          out_ready,
    output commit_t      out_data
);

    logic                  dec_valid;
    logic                  dec_ready;
    ctrl_t                 dec_data;
    logic                  opr_valid;
    logic                  opr_ready;
    oper_t                 opr_data;
    logic [REG_ADDR_W-1:0] raddr1;
    logic [REG_ADDR_W-1:0] raddr2;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;
    bypass_t               bypass;
    logic                  rf_wen;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;

    rvseed_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .dec_ready (dec_ready),
        .in_ready  (in_ready),
        .dec_valid (dec_valid),
        .dec_data  (dec_data)
    );

    rvseed_operand u_operand (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_data  (dec_data),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .bypass    (bypass),
        .opr_ready (opr_ready),
        .dec_ready (dec_ready),
        .raddr1    (raddr1),
        .raddr2    (raddr2),
        .opr_valid (opr_valid),
        .opr_data  (opr_data)
    );

    rvseed_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .wen    (rf_wen),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    rvseed_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .opr_valid (opr_valid),
        .opr_data  (opr_data),
        .out_ready (out_ready),
        .opr_ready (opr_ready),
        .bypass    (bypass),
        .rf_wen    (rf_wen),
        .rf_waddr  (rf_waddr),
        .rf_wdata  (rf_wdata),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

/* source/rvseed_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module rvseed_decode import rvseed_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        in_valid,
    input  wire fetch_t in_data,
    input  wire        dec_ready,
    output logic       in_ready,
    output logic       dec_valid,
    output ctrl_t      dec_data
);

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic                  writes;
    ctrl_t                 ctrl_d;

    assign opcode = opcode_e'(in_data.inst[6:0]);
    assign funct3 = in_data.inst[F3_LSB +: 3];
    assign funct7 = in_data.inst[F7_LSB +: 7];
    assign rd     = in_data.inst[RD_LSB +: REG_ADDR_W];
    assign rs1    = in_data.inst[RS1_LSB +: REG_ADDR_W];
    assign rs2    = in_data.inst[RS2_LSB +: REG_ADDR_W];

    always_comb begin
        ctrl_d         = '0;
        ctrl_d.pc      = in_data.pc;
        ctrl_d.inst    = in_data.inst;
        ctrl_d.alu_op  = ALU_AND;
        ctrl_d.alu_src = SRC_REG;
        ctrl_d.imm_op  = IMM_I;
        writes         = 1'b0;
        case (opcode)
            OPC_R: begin
                writes     = 1'b1;
                ctrl_d.rs1 = rs1;
                ctrl_d.rs2 = rs2;
                if (funct3 == F3_ADD && funct7 == F7_ADD)
                    ctrl_d.alu_op = ALU_ADD;
                else if (funct3 == F3_ADD && funct7 == F7_SUB)
                    ctrl_d.alu_op = ALU_SUB;
                else
                    ctrl_d.illegal = 1'b1;
            end
            OPC_I: begin
                writes         = 1'b1;
                ctrl_d.rs1     = rs1;
                ctrl_d.alu_op  = ALU_ADD;
                ctrl_d.alu_src = SRC_IMM;
                ctrl_d.illegal = (funct3 != F3_ADD); // addi only
            end
            OPC_B: begin
                ctrl_d.rs1     = rs1;
                ctrl_d.rs2     = rs2;
                ctrl_d.branch  = 1'b1;
                ctrl_d.alu_op  = ALU_SUB; // nonzero difference means taken
                ctrl_d.imm_op  = IMM_B;
                ctrl_d.illegal = (funct3 != F3_BNE);
            end
            OPC_S: begin
                ctrl_d.rs1     = rs1;
                ctrl_d.rs2     = rs2;
                ctrl_d.store   = 1'b1;
                ctrl_d.alu_op  = ALU_ADD; // address
                ctrl_d.alu_src = SRC_IMM;
                ctrl_d.imm_op  = IMM_S;
                ctrl_d.illegal = (funct3 != F3_SD);
            end
            OPC_JAL: begin
                writes         = 1'b1;
                ctrl_d.jump    = 1'b1;
                ctrl_d.alu_op  = ALU_ADD;
                ctrl_d.alu_src = SRC_FOUR_PC; // link value
                ctrl_d.imm_op  = IMM_J;
            end
            OPC_JALR: begin
                writes         = 1'b1;
                ctrl_d.rs1     = rs1;
                ctrl_d.jump    = 1'b1;
                ctrl_d.jalr    = 1'b1;
                ctrl_d.alu_op  = ALU_ADD;
                ctrl_d.alu_src = SRC_FOUR_PC;
                ctrl_d.illegal = (funct3 != F3_JALR);
            end
            OPC_LUI: begin
                writes         = 1'b1;
                ctrl_d.alu_op  = ALU_ADD; // x0 + imm
                ctrl_d.alu_src = SRC_IMM;
                ctrl_d.imm_op  = IMM_U;
            end
            OPC_AUIPC: begin
                writes         = 1'b1;
                ctrl_d.alu_op  = ALU_ADD;
                ctrl_d.alu_src = SRC_IMM_PC;
                ctrl_d.imm_op  = IMM_U;
            end
            OPC_SYS: begin
                ctrl_d.halt    = (in_data.inst == EBREAK_INST);
                ctrl_d.illegal = (in_data.inst != EBREAK_INST); // ecall and csr not supported
            end
            default: ctrl_d.illegal = 1'b1;
        endcase
        // an unsupported code must not write, branch or store
        if (ctrl_d.illegal) begin
            writes        = 1'b0;
            ctrl_d.branch = 1'b0;
            ctrl_d.jump   = 1'b0;
            ctrl_d.jalr   = 1'b0;
            ctrl_d.store  = 1'b0;
        end
        ctrl_d.rd  = writes ? rd : '0;
        ctrl_d.wen = writes && (rd != '0); // x0 never written
    end

    assign in_ready = !dec_valid || dec_ready;

    always_ff @(posedge clk) begin
        if (!rst_n)
            dec_valid <= 1'b0;
        else if (in_ready)
            dec_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            dec_data <= ctrl_d;
    end

endmodule

`default_nettype wire

/* source/rvseed_execute.sv */
`timescale 1ns/100ps
`default_nettype none

module rvseed_execute import rvseed_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   opr_valid,
    input  wire oper_t            opr_data,
    input  wire                   out_ready,
    output logic                  opr_ready,
    output bypass_t               bypass,
    output logic                  rf_wen,
    output logic [REG_ADDR_W-1:0] rf_waddr,
    output logic [XLEN-1:0]       rf_wdata,
    output logic                  out_valid,
    output commit_t               out_data
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] next_pc;
    logic            taken;
    logic            load;
    commit_t         commit_d;

    always_comb begin
        case (opr_data.alu_src)
            SRC_IMM:     {op_a, op_b} = {opr_data.rs1_val, opr_data.imm};
            SRC_FOUR_PC: {op_a, op_b} = {opr_data.pc, 64'd4};
            SRC_IMM_PC:  {op_a, op_b} = {opr_data.pc, opr_data.imm};
            default:     {op_a, op_b} = {opr_data.rs1_val, opr_data.rs2_val};
        endcase
    end

    always_comb begin
        case (opr_data.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            default: result = op_a & op_b;
        endcase
    end

    assign pc_plus4 = opr_data.pc + 64'd4;
    assign jalr_sum = opr_data.rs1_val + opr_data.imm;
    assign taken    = opr_data.branch && (result != '0); // bne

    always_comb begin
        if (opr_data.jalr)
            next_pc = {jalr_sum[XLEN-1:1], 1'b0};
        else if (taken || opr_data.jump)
            next_pc = opr_data.pc + opr_data.imm;
        else
            next_pc = pc_plus4;
    end

    always_comb begin
        commit_d            = '0;
        commit_d.pc         = opr_data.pc;
        commit_d.next_pc    = next_pc;
        commit_d.inst       = opr_data.inst;
        commit_d.rd         = opr_data.rd;
        commit_d.wen        = opr_data.wen;
        commit_d.wdata      = opr_data.wen ? result : '0;
        commit_d.store      = opr_data.store;
        commit_d.store_addr = opr_data.store ? result : '0;
        commit_d.store_data = opr_data.store ? opr_data.rs2_val : '0;
        commit_d.halt       = opr_data.halt;
        commit_d.illegal    = opr_data.illegal;
    end

    assign opr_ready = !out_valid || out_ready;
    assign load      = opr_valid && opr_ready;

    assign bypass   = '{valid: opr_valid && opr_data.wen, rd: opr_data.rd, data: result};
    assign rf_wen   = load && opr_data.wen; // write lands with the commit
    assign rf_waddr = opr_data.rd;
    assign rf_wdata = result;

    always_ff @(posedge clk) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (opr_ready)
            out_valid <= opr_valid;
    end

    always_ff @(posedge clk) begin
        if (load)
            out_data <= commit_d;
    end

endmodule

`default_nettype wire

/* source/rvseed_operand.sv */
`timescale 1ns/100ps
`default_nettype none

module rvseed_operand import rvseed_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   dec_valid,
    input  wire ctrl_t            dec_data,
    input  wire [XLEN-1:0]        rdata1,
    input  wire [XLEN-1:0]        rdata2,
    input  wire bypass_t          bypass,
    input  wire                   opr_ready,
    output logic                  dec_ready,
    output logic [REG_ADDR_W-1:0] raddr1,
    output logic [REG_ADDR_W-1:0] raddr2,
    output logic                  opr_valid,
    output oper_t                 opr_data
);

    logic [INST_W-1:0] inst;
    logic [XLEN-1:0]   imm;
    oper_t             opr_d;

    assign inst   = dec_data.inst;
    assign raddr1 = dec_data.rs1;
    assign raddr2 = dec_data.rs2;

    always_comb begin
        case (dec_data.imm_op)
            IMM_S:   imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
            IMM_B:   imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            IMM_J:   imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            IMM_U:   imm = {{32{inst[31]}}, inst[31:12], 12'b0};
            default: imm = {{52{inst[31]}}, inst[31:20]};
        endcase
    end

    always_comb begin
        opr_d         = '0;
        opr_d.pc      = dec_data.pc;
        opr_d.inst    = dec_data.inst;
        opr_d.rd      = dec_data.rd;
        opr_d.wen     = dec_data.wen;
        opr_d.branch  = dec_data.branch;
        opr_d.jump    = dec_data.jump;
        opr_d.jalr    = dec_data.jalr;
        opr_d.store   = dec_data.store;
        opr_d.halt    = dec_data.halt;
        opr_d.illegal = dec_data.illegal;
        opr_d.alu_op  = dec_data.alu_op;
        opr_d.alu_src = dec_data.alu_src;
        opr_d.imm     = imm;
        // execute writes on the same edge, so take its result directly
        opr_d.rs1_val = (bypass.valid && bypass.rd == dec_data.rs1) ? bypass.data : rdata1;
        opr_d.rs2_val = (bypass.valid && bypass.rd == dec_data.rs2) ? bypass.data : rdata2;
    end

    assign dec_ready = !opr_valid || opr_ready;

    always_ff @(posedge clk) begin
        if (!rst_n)
            opr_valid <= 1'b0;
        else if (dec_ready)
            opr_valid <= dec_valid;
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready)
            opr_data <= opr_d;
    end

endmodule

`default_nettype wire

/* source/rvseed_pkg.sv */
`default_nettype none

package rvseed_pkg;

    localparam int XLEN       = 64;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // instruction field positions
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int F7_LSB  = 25;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_SD   = 3'b011;
    localparam logic [2:0] F3_JALR = 3'b000;
    localparam logic [6:0] F7_ADD  = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    localparam logic [INST_W-1:0] EBREAK_INST = 32'h0010_0073;

    typedef enum logic [6:0] {
        OPC_R     = 7'b0110011,
        OPC_I     = 7'b0010011,
        OPC_B     = 7'b1100011,
        OPC_S     = 7'b0100011,
        OPC_JAL   = 7'b1101111,
        OPC_JALR  = 7'b1100111,
        OPC_LUI   = 7'b0110111,
        OPC_AUIPC = 7'b0010111,
        OPC_SYS   = 7'b1110011
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG,     // rs1 + rs2
        SRC_IMM,     // rs1 + imm
        SRC_FOUR_PC, // pc + 4
        SRC_IMM_PC   // pc + imm
    } alu_src_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_J,
        IMM_U
    } imm_op_e;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [INST_W-1:0] inst;
    } fetch_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [INST_W-1:0]     inst;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  wen;
        logic                  branch;
        logic                  jump;
        logic                  jalr;
        logic                  store;
        logic                  halt;
        logic                  illegal;
        alu_op_e               alu_op;
        alu_src_e              alu_src;
        imm_op_e               imm_op;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [INST_W-1:0]     inst;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic                  branch;
        logic                  jump;
        logic                  jalr;
        logic                  store;
        logic                  halt;
        logic                  illegal;
        alu_op_e               alu_op;
        alu_src_e              alu_src;
        logic [XLEN-1:0]       rs1_val;
        logic [XLEN-1:0]       rs2_val;
        logic [XLEN-1:0]       imm;
    } oper_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } bypass_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       next_pc;
        logic [INST_W-1:0]     inst;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic [XLEN-1:0]       wdata;
        logic                  store;
        logic [XLEN-1:0]       store_addr;
        logic [XLEN-1:0]       store_data;
        logic                  halt;
        logic                  illegal;
    } commit_t;

endpackage

`default_nettype wire

/* source/rvseed_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module rvseed_regfile import rvseed_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire [REG_ADDR_W-1:0] raddr1,
    input  wire [REG_ADDR_W-1:0] raddr2,
    input  wire                  wen,
    input  wire [REG_ADDR_W-1:0] waddr,
    input  wire [XLEN-1:0]       wdata,
    output logic [XLEN-1:0]      rdata1,
    output logic [XLEN-1:0]      rdata2
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // combinational read, new data visible after the write edge
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[waddr] <= wdata; // x0 kept clear by decode
        end
    end

endmodule

`default_nettype wire
